//--- list.f
+incdir+tests
design/sb_pkg.sv
design/sb_prio_sel.sv
design/sb_entry_store.sv
design/sb_clobber.sv
design/sb_operand_fwd.sv
design/scoreboard.sv
tests/tb_scoreboard.sv

//--- Makefile
# Verilator build, run and lint for the scoreboard

VERILATOR ?= verilator
TOP       ?= tb_scoreboard
DUT_TOP   ?= scoreboard
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= test passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILE_LIST) --Mdir $(BUILD_DIR)

# the result is decided by the pass line in the simulator output
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(DUT_TOP) \
		-f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_scoreboard_tasks.svh
// --------------------------------------------------
// scoreboard testbench tasks
// typed compare tasks, drive tasks for issue,
// write-back, commit and flush, and the five
// directed tests
// --------------------------------------------------

`ifndef TB_SCOREBOARD_TASKS_SVH
`define TB_SCOREBOARD_TASKS_SVH

// --------------------------------------------------
// compare tasks
// --------------------------------------------------
task automatic check_entry(input string name, input sb_entry_t act, input sb_entry_t exp);
  if (act !== exp) begin
    $display("ERROR at %0t: %s = %h, expected %h", $time, name, act, exp);
    errors++;
  end
endtask

task automatic check_fu(input string name, input fu_t act, input fu_t exp);
  if (act !== exp) begin
    $display("ERROR at %0t: %s = %s, expected %s", $time, name, act.name(), exp.name());
    errors++;
  end
endtask

// data only matters on a valid operand
task automatic check_operand(input string name, input operand_t act, input operand_t exp);
  if (act.valid !== exp.valid || (exp.valid && act.data !== exp.data)) begin
    $display("ERROR at %0t: %s = %h, expected %h", $time, name, act, exp);
    errors++;
  end
endtask

task automatic check_bit(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    $display("ERROR at %0t: %s = %b, expected %b", $time, name, act, exp);
    errors++;
  end
endtask

task automatic check_clobbers_none();
  for (int r = 0; r < NR_REGS; r++) begin
    check_fu($sformatf("rd_clobber_o[%0d]", r), rd_clobber_o[r], NONE);
  end
endtask

task automatic end_test(input string name, input int err_start);
  tests_run++;
  if (errors == err_start) begin
    $display("%s: ok", name);
  end else begin
    tests_failed++;
    $display("%s: %0d errors", name, errors - err_start);
  end
endtask

// --------------------------------------------------
// drive tasks
// --------------------------------------------------
task automatic reset_model();
  for (int e = 0; e < NR_ENTRIES; e++) begin
    model_q[e] = '0;
  end
  model_issue_id  = '0;
  model_commit_id = '0;
endtask

// one decoded instruction through the issue handshake
task automatic issue_instr(input fu_t fu, input logic [REG_ADDR_W-1:0] rd);
  sb_entry_t instr;
  sb_entry_t exp;
  instr    = '0;
  instr.pc = $random(seed);
  instr.fu = fu;
  instr.rd = rd;
  exp          = instr;
  exp.trans_id = model_issue_id;
  @(posedge clk_i);
  decoded_instr_i       <= instr;
  decoded_instr_valid_i <= 1'b1;
  issue_ack_i           <= 1'b1;
  @(negedge clk_i);
  check_bit("issue_instr_valid_o", issue_instr_valid_o, 1'b1);
  check_bit("decoded_instr_ack_o", decoded_instr_ack_o, 1'b1);
  check_entry("issue_instr_o", issue_instr_o, exp);
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b0;
  issue_ack_i           <= 1'b0;
  // a NONE entry has nothing to wait for
  exp.issued              = 1'b1;
  exp.valid               = (fu == NONE);
  model_q[model_issue_id] = exp;
  model_issue_id          = model_issue_id + 1'b1;
endtask

// called right after a rising edge, the pulse ends with clear_wb
task automatic set_wb(input int port, input logic [TRANS_ID_W-1:0] id, input logic ex);
  wb_t wb;
  wb.valid    = 1'b1;
  wb.trans_id = id;
  wb.data     = $random(seed);
  wb.ex_valid = ex;
  wb_i[port] <= wb;
  if (model_q[id].issued) begin
    model_q[id].valid    = 1'b1;
    model_q[id].result   = wb.data;
    model_q[id].ex_valid = ex;
  end
endtask

task automatic clear_wb();
  @(posedge clk_i);
  wb_i <= '0;
endtask

// waits for the head to be ready, checks it and acks it
task automatic commit_head();
  sb_entry_t exp;
  int        waited;
  exp    = model_q[model_commit_id];
  waited = 0;
  @(negedge clk_i);
  while (!commit_instr_o.valid && waited < COMMIT_WAIT_CYCLES) begin
    @(negedge clk_i);
    waited++;
  end
  if (!commit_instr_o.valid) begin
    $display("entry %0d never became ready to commit at %0t", model_commit_id, $time);
    errors++;
  end else begin
    check_entry("commit_instr_o", commit_instr_o, exp);
    @(posedge clk_i);
    commit_ack_i <= 1'b1;
    @(posedge clk_i);
    commit_ack_i <= 1'b0;
    model_q[model_commit_id] = '0;
    model_commit_id          = model_commit_id + 1'b1;
  end
endtask

task automatic flush_sb();
  @(posedge clk_i);
  flush_i <= 1'b1;
  @(posedge clk_i);
  flush_i <= 1'b0;
  reset_model();
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic test_in_order();
  int err_start;
  err_start = errors;
  // state straight out of reset
  @(negedge clk_i);
  check_bit("sb_full_o", sb_full_o, 1'b0);
  check_bit("commit_instr_o.valid", commit_instr_o.valid, 1'b0);
  check_bit("issue_instr_valid_o", issue_instr_valid_o, 1'b0);
  check_clobbers_none();
  issue_instr(ALU, 5'd1);
  issue_instr(LOAD, 5'd2);
  issue_instr(NONE, 5'd3);
  @(posedge clk_i);
  set_wb(0, 0, 1'b0);
  set_wb(1, 1, 1'b0);
  clear_wb();
  repeat (3) commit_head();
  end_test("in-order issue and commit", err_start);
endtask

task automatic test_full();
  int err_start;
  err_start = errors;
  flush_sb();
  for (int i = 0; i < NR_ENTRIES; i++) begin
    issue_instr(STORE, 5'(i + 8));
  end
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b1;
  @(negedge clk_i);
  check_bit("sb_full_o", sb_full_o, 1'b1);
  check_bit("decoded_instr_ack_o", decoded_instr_ack_o, 1'b0);
  check_bit("issue_instr_valid_o", issue_instr_valid_o, 1'b0);
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b0;
  set_wb(0, model_commit_id, 1'b0);
  clear_wb();
  commit_head();
  @(negedge clk_i);
  check_bit("sb_full_o", sb_full_o, 1'b0);
  // space is free again, only the branch holds issue back
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b1;
  unresolved_branch_i   <= 1'b1;
  @(negedge clk_i);
  check_bit("issue_instr_valid_o", issue_instr_valid_o, 1'b0);
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b0;
  unresolved_branch_i   <= 1'b0;
  // the freed slot 0 takes the next instruction
  issue_instr(ALU, 5'd20);
  end_test("full and back-pressure", err_start);
endtask

task automatic test_clobber();
  int err_start;
  err_start = errors;
  flush_sb();
  issue_instr(MULT, 5'd5);
  issue_instr(ALU, 5'd0);
  @(negedge clk_i);
  check_fu("rd_clobber_o[5]", rd_clobber_o[5], MULT);
  check_fu("rd_clobber_o[0]", rd_clobber_o[0], NONE);
  @(posedge clk_i);
  set_wb(0, 0, 1'b0);
  clear_wb();
  commit_head();
  @(negedge clk_i);
  check_fu("rd_clobber_o[5]", rd_clobber_o[5], NONE);
  end_test("clobber", err_start);
endtask

task automatic test_forwarding();
  int       err_start;
  operand_t exp_op;
  err_start = errors;
  flush_sb();
  issue_instr(ALU, 5'd7);
  @(posedge clk_i);
  rs1_i <= 5'd7;
  set_wb(0, 0, 1'b0);
  @(negedge clk_i);
  exp_op.valid = 1'b1;
  exp_op.data  = model_q[0].result;
  check_operand("rs1_o", rs1_o, exp_op);
  clear_wb();
  @(negedge clk_i);
  check_operand("rs1_o", rs1_o, exp_op);
  // a pulse on a second x7 entry beats the stored result
  issue_instr(ALU, 5'd7);
  @(posedge clk_i);
  set_wb(1, 1, 1'b0);
  @(negedge clk_i);
  exp_op.data = model_q[1].result;
  check_operand("rs1_o", rs1_o, exp_op);
  clear_wb();
  issue_instr(ALU, 5'd9);
  @(posedge clk_i);
  rs2_i <= 5'd9;
  set_wb(0, 2, 1'b1);
  @(negedge clk_i);
  exp_op.valid = 1'b0;
  check_operand("rs2_o", rs2_o, exp_op);
  clear_wb();
  issue_instr(ALU, 5'd0);
  @(posedge clk_i);
  rs1_i <= 5'd0;
  set_wb(1, 3, 1'b0);
  @(negedge clk_i);
  check_operand("rs1_o", rs1_o, exp_op);
  clear_wb();
  @(negedge clk_i);
  check_operand("rs1_o", rs1_o, exp_op);
  end_test("forwarding", err_start);
endtask

task automatic test_flush();
  int        err_start;
  sb_entry_t instr;
  err_start = errors;
  flush_sb();
  issue_instr(CSR, 5'd4);
  instr    = '0;
  instr.pc = $random(seed);
  instr.fu = CSR;
  instr.rd = 5'd6;
  @(posedge clk_i);
  decoded_instr_i        <= instr;
  decoded_instr_valid_i  <= 1'b1;
  issue_ack_i            <= 1'b1;
  flush_unissued_instr_i <= 1'b1;
  @(posedge clk_i);
  decoded_instr_valid_i  <= 1'b0;
  issue_ack_i            <= 1'b0;
  flush_unissued_instr_i <= 1'b0;
  @(negedge clk_i);
  check_fu("rd_clobber_o[6]", rd_clobber_o[6], NONE);
  // slot 1 must still be free for the next one
  for (int i = 1; i < NR_ENTRIES; i++) begin
    issue_instr(CSR, 5'(i + 10));
  end
  @(negedge clk_i);
  check_bit("sb_full_o", sb_full_o, 1'b1);
  @(posedge clk_i);
  set_wb(0, 0, 1'b0);
  clear_wb();
  @(negedge clk_i);
  check_bit("commit_instr_o.valid", commit_instr_o.valid, 1'b1);
  flush_sb();
  @(negedge clk_i);
  check_bit("sb_full_o", sb_full_o, 1'b0);
  check_bit("commit_instr_o.valid", commit_instr_o.valid, 1'b0);
  check_clobbers_none();
  issue_instr(ALU, 5'd1);
  end_test("flush", err_start);
endtask

`endif

//--- tests/tb_scoreboard.sv
// --------------------------------------------------
// scoreboard testbench top
// clock, reset, watchdog, DUT instance, model of
// the expected entries and the directed test sequence
// --------------------------------------------------

`timescale 1ns/1ps

module tb_scoreboard;

  import sb_pkg::*;

  localparam int CLK_PERIOD         = 8;
  localparam int RESET_CYCLES       = 16;
  localparam int NUM_TESTS          = 5;
  // longest test, including the worst-case commit waits
  localparam int MAX_TEST_CYCLES    = 100;
  localparam int COMMIT_WAIT_CYCLES = 20;

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------
  logic                             clk_i = 1'b0;
  logic                             rst_ni;
  logic                             flush_i;
  logic                             flush_unissued_instr_i;
  logic                             unresolved_branch_i;
  sb_entry_t                        decoded_instr_i;
  logic                             decoded_instr_valid_i;
  logic                             decoded_instr_ack_o;
  sb_entry_t                        issue_instr_o;
  logic                             issue_instr_valid_o;
  logic                             issue_ack_i;
  wb_t       [NR_WB_PORTS-1:0]      wb_i;
  sb_entry_t                        commit_instr_o;
  logic                             commit_ack_i;
  logic                             sb_full_o;
  fu_t       [NR_REGS-1:0]          rd_clobber_o;
  logic      [REG_ADDR_W-1:0]       rs1_i;
  logic      [REG_ADDR_W-1:0]       rs2_i;
  operand_t                         rs1_o;
  operand_t                         rs2_o;

  // --------------------------------------------------
  // model state and bookkeeping
  // --------------------------------------------------
  // expected contents of each slot, indexed by trans_id
  sb_entry_t             model_q [NR_ENTRIES];
  logic [TRANS_ID_W-1:0] model_issue_id;
  logic [TRANS_ID_W-1:0] model_commit_id;

  integer seed = 48506;
  int     errors;
  int     tests_run;
  int     tests_failed;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  scoreboard i_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_instr_i(flush_unissued_instr_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .wb_i                  (wb_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .sb_full_o             (sb_full_o),
    .rd_clobber_o          (rd_clobber_o),
    .rs1_i                 (rs1_i),
    .rs2_i                 (rs2_i),
    .rs1_o                 (rs1_o),
    .rs2_o                 (rs2_o)
  );

  `include "tb_scoreboard_tasks.svh"

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    rst_ni                 = 1'b0;
    flush_i                = 1'b0;
    flush_unissued_instr_i = 1'b0;
    unresolved_branch_i    = 1'b0;
    decoded_instr_i        = '0;
    decoded_instr_valid_i  = 1'b0;
    issue_ack_i            = 1'b0;
    wb_i                   = '0;
    commit_ack_i           = 1'b0;
    rs1_i                  = '0;
    rs2_i                  = '0;
    errors                 = 0;
    tests_run              = 0;
    tests_failed           = 0;
    reset_model();

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_in_order();
    test_full();
    test_clobber();
    test_forwarding();
    test_flush();

    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // bounds the whole run
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * MAX_TEST_CYCLES));
    $display("watchdog expired, the tests did not finish in time");
    $display("test failed");
    $finish;
  end

endmodule

//--- design/scoreboard.sv
// --------------------------------------------------
// scoreboard top level
// entry store, integer clobber search and
// forwarding for the two read ports
// --------------------------------------------------

`timescale 1ns/1ps

module scoreboard (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          flush_i,
  input  logic                                          flush_unissued_instr_i,
  input  logic                                          unresolved_branch_i,
  // decode side
  input  sb_pkg::sb_entry_t                             decoded_instr_i,
  input  logic                                          decoded_instr_valid_i,
  output logic                                          decoded_instr_ack_o,
  // issue side
  output sb_pkg::sb_entry_t                             issue_instr_o,
  output logic                                          issue_instr_valid_o,
  input  logic                                          issue_ack_i,
  // results from the functional units
  input  sb_pkg::wb_t       [sb_pkg::NR_WB_PORTS-1:0]   wb_i,
  // commit side
  output sb_pkg::sb_entry_t                             commit_instr_o,
  input  logic                                          commit_ack_i,
  output logic                                          sb_full_o,
  // to the issue stage
  output sb_pkg::fu_t       [sb_pkg::NR_REGS-1:0]       rd_clobber_o,
  input  logic              [sb_pkg::REG_ADDR_W-1:0]    rs1_i,
  input  logic              [sb_pkg::REG_ADDR_W-1:0]    rs2_i,
  output sb_pkg::operand_t                              rs1_o,
  output sb_pkg::operand_t                              rs2_o
);

  import sb_pkg::*;

  sb_entry_t [NR_ENTRIES-1:0] entries;

  sb_entry_store i_store (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_instr_i(flush_unissued_instr_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .wb_i                  (wb_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .sb_full_o             (sb_full_o),
    .entries_o             (entries)
  );

  sb_clobber i_clobber (
    .entries_i   (entries),
    .rd_clobber_o(rd_clobber_o)
  );

  // ---- read ports ----
  sb_operand_fwd i_fwd_rs1 (
    .rs_i     (rs1_i),
    .wb_i     (wb_i),
    .entries_i(entries),
    .operand_o(rs1_o)
  );

  sb_operand_fwd i_fwd_rs2 (
    .rs_i     (rs2_i),
    .wb_i     (wb_i),
    .entries_i(entries),
    .operand_o(rs2_o)
  );

endmodule

//--- design/sb_operand_fwd.sv
// --------------------------------------------------
// operand forwarding, one read port
// write-back pulses first, then completed entries,
// never valid for x0
// --------------------------------------------------

`timescale 1ns/1ps

module sb_operand_fwd (
  input  logic              [sb_pkg::REG_ADDR_W-1:0]  rs_i,
  input  sb_pkg::wb_t       [sb_pkg::NR_WB_PORTS-1:0] wb_i,
  input  sb_pkg::sb_entry_t [sb_pkg::NR_ENTRIES-1:0]  entries_i,
  output sb_pkg::operand_t                            operand_o
);

  import sb_pkg::*;

  localparam int unsigned NR_SRC = NR_WB_PORTS + NR_ENTRIES;

  logic [NR_SRC-1:0]                fwd_req;
  logic [NR_SRC-1:0][XLEN-1:0]      fwd_data;
  logic                             sel_valid;
  logic [XLEN-1:0]                  sel_data;

  // ---- write-back ports, the freshest values ----
  for (genvar k = 0; k < NR_WB_PORTS; k++) begin : gen_wb_src
    assign fwd_req[k] = wb_i[k].valid & ~wb_i[k].ex_valid &
                        (entries_i[wb_i[k].trans_id].rd == rs_i);
    assign fwd_data[k] = wb_i[k].data;
  end

  // ---- stored results ----
  for (genvar e = 0; e < NR_ENTRIES; e++) begin : gen_entry_src
    assign fwd_req[NR_WB_PORTS+e] = entries_i[e].issued & entries_i[e].valid &
                                    (entries_i[e].rd == rs_i);
    assign fwd_data[NR_WB_PORTS+e] = entries_i[e].result;
  end

  sb_prio_sel #(
    .NUM_IN   (NR_SRC),
    .payload_t(logic [XLEN-1:0])
  ) i_sel (
    .req_i  (fwd_req),
    .data_i (fwd_data),
    .valid_o(sel_valid),
    .data_o (sel_data)
  );

  // x0 reads come from the register file
  assign operand_o.valid = sel_valid & (|rs_i);
  assign operand_o.data  = sel_data;

endmodule

//--- design/sb_clobber.sv
// --------------------------------------------------
// destination clobber search
// per integer register, the functional unit of the
// lowest-index issued entry that will write it
// --------------------------------------------------

`timescale 1ns/1ps

module sb_clobber (
  input  sb_pkg::sb_entry_t [sb_pkg::NR_ENTRIES-1:0] entries_i,
  output sb_pkg::fu_t       [sb_pkg::NR_REGS-1:0]    rd_clobber_o
);

  import sb_pkg::*;

  // one request per entry plus the NONE default on top
  logic [NR_REGS-1:0][NR_ENTRIES:0] clobber_req;
  fu_t  [NR_ENTRIES:0]              clobber_fu;

  always_comb begin
    clobber_req = '0;
    clobber_fu[NR_ENTRIES] = NONE;
    for (int e = 0; e < NR_ENTRIES; e++) begin
      clobber_fu[e] = entries_i[e].fu;
    end
    // x0 is never clobbered, so its row stays empty
    for (int r = 1; r < NR_REGS; r++) begin
      clobber_req[r][NR_ENTRIES] = 1'b1;
      for (int e = 0; e < NR_ENTRIES; e++) begin
        clobber_req[r][e] = entries_i[e].issued && (entries_i[e].rd == REG_ADDR_W'(r));
      end
    end
  end

  for (genvar r = 0; r < NR_REGS; r++) begin : gen_reg
    sb_prio_sel #(
      .NUM_IN   (NR_ENTRIES + 1),
      .payload_t(fu_t)
    ) i_sel (
      .req_i  (clobber_req[r]),
      .data_i (clobber_fu),
      .valid_o(),
      .data_o (rd_clobber_o[r])
    );
  end

  always_comb begin
    assert (rd_clobber_o[0] == NONE)
    else $error("x0 reported as clobbered");
  end

endmodule

//--- design/sb_entry_store.sv
// --------------------------------------------------
// scoreboard entry store
// circular buffer of in-flight instructions with
// issue and commit pointers and an occupancy count,
// issue/commit handshakes, write-back, completion of
// NONE entries and flush
// --------------------------------------------------

`timescale 1ns/1ps

module sb_entry_store (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          flush_i,
  input  logic                                          flush_unissued_instr_i,
  input  logic                                          unresolved_branch_i,
  input  sb_pkg::sb_entry_t                             decoded_instr_i,
  input  logic                                          decoded_instr_valid_i,
  output logic                                          decoded_instr_ack_o,
  output sb_pkg::sb_entry_t                             issue_instr_o,
  output logic                                          issue_instr_valid_o,
  input  logic                                          issue_ack_i,
  input  sb_pkg::wb_t       [sb_pkg::NR_WB_PORTS-1:0]   wb_i,
  output sb_pkg::sb_entry_t                             commit_instr_o,
  input  logic                                          commit_ack_i,
  output logic                                          sb_full_o,
  output sb_pkg::sb_entry_t [sb_pkg::NR_ENTRIES-1:0]    entries_o
);

  import sb_pkg::*;

  sb_entry_t [NR_ENTRIES-1:0] mem_q, mem_n;

  logic [TRANS_ID_W-1:0] issue_ptr_q, issue_ptr_n;
  logic [TRANS_ID_W-1:0] commit_ptr_q, commit_ptr_n;
  // one bit wider than the pointers
  logic [TRANS_ID_W:0]   cnt_q, cnt_n;
  logic                  full;
  logic                  issue_en;

  assign full      = cnt_q[TRANS_ID_W];
  assign sb_full_o = full;
  assign entries_o = mem_q;

  // --------------------------------------------------
  // issue and commit ports
  // --------------------------------------------------
  always_comb begin
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_ptr_q;
    issue_instr_valid_o    = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
    decoded_instr_ack_o    = issue_ack_i & ~full;
  end

  always_comb begin
    commit_instr_o          = mem_q[commit_ptr_q];
    commit_instr_o.trans_id = commit_ptr_q;
  end

  assign issue_en = decoded_instr_valid_i & decoded_instr_ack_o & ~flush_unissued_instr_i;

  // --------------------------------------------------
  // next buffer state where later updates take precedence
  // --------------------------------------------------
  always_comb begin
    mem_n = mem_q;

    if (issue_en) begin
      mem_n[issue_ptr_q]          = decoded_instr_i;
      mem_n[issue_ptr_q].trans_id = issue_ptr_q;
      mem_n[issue_ptr_q].valid    = 1'b0;
      mem_n[issue_ptr_q].ex_valid = 1'b0;
      mem_n[issue_ptr_q].issued   = 1'b1;
    end

    // nothing to wait for on a NONE entry
    for (int e = 0; e < NR_ENTRIES; e++) begin
      if (mem_q[e].issued && mem_q[e].fu == NONE) begin
        mem_n[e].valid = 1'b1;
      end
    end

    // late results after a flush land on free slots and are dropped
    for (int k = 0; k < NR_WB_PORTS; k++) begin
      if (wb_i[k].valid && mem_q[wb_i[k].trans_id].issued) begin
        mem_n[wb_i[k].trans_id].valid    = 1'b1;
        mem_n[wb_i[k].trans_id].result   = wb_i[k].data;
        mem_n[wb_i[k].trans_id].ex_valid = wb_i[k].ex_valid;
      end
    end

    if (commit_ack_i) begin
      mem_n[commit_ptr_q].issued = 1'b0;
      mem_n[commit_ptr_q].valid  = 1'b0;
    end

    if (flush_i) begin
      for (int e = 0; e < NR_ENTRIES; e++) begin
        mem_n[e].issued   = 1'b0;
        mem_n[e].valid    = 1'b0;
        mem_n[e].ex_valid = 1'b0;
      end
    end
  end

  // pointers and count
  assign issue_ptr_n  = flush_i ? '0 : issue_ptr_q + TRANS_ID_W'(issue_en);
  assign commit_ptr_n = flush_i ? '0 : commit_ptr_q + TRANS_ID_W'(commit_ack_i);
  assign cnt_n        = flush_i ? '0 :
                        cnt_q - (TRANS_ID_W + 1)'(commit_ack_i) + (TRANS_ID_W + 1)'(issue_en);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q        <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      mem_q        <= mem_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      cnt_q        <= cnt_n;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  initial begin
    assert (NR_ENTRIES == 2 ** TRANS_ID_W && (NR_ENTRIES & (NR_ENTRIES - 1)) == 0)
    else $fatal(1, "scoreboard size must be a power of two");
  end

  a_issue_ack_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_instr_valid_o
  ) else $error("issue ack without a valid instruction");

  a_commit_ack_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_instr_o.valid
  ) else $error("commit ack on an entry without a result");

  // two units never finish the same transaction in one cycle
  for (genvar i = 0; i < NR_WB_PORTS; i++) begin : gen_wb_chk_i
    for (genvar j = i + 1; j < NR_WB_PORTS; j++) begin : gen_wb_chk_j
      a_wb_unique_id: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (wb_i[i].valid && wb_i[j].valid) |-> (wb_i[i].trans_id != wb_i[j].trans_id)
      ) else $error("write-back ports %0d and %0d share a trans_id", i, j);
    end
  end

endmodule

//--- design/sb_prio_sel.sv
// --------------------------------------------------
// fixed-priority selector
// passes the payload of the lowest-index request,
// zero and valid low when nothing is requested
// --------------------------------------------------

`timescale 1ns/1ps

module sb_prio_sel #(
  parameter int unsigned NUM_IN = 4,
  parameter type payload_t = logic
) (
  input  logic     [NUM_IN-1:0] req_i,
  input  payload_t [NUM_IN-1:0] data_i,
  output logic                  valid_o,
  output payload_t              data_o
);

  // walk from the top down so the lowest index is the last to win
  always_comb begin
    valid_o = 1'b0;
    data_o  = payload_t'(0);
    for (int i = NUM_IN - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        valid_o = 1'b1;
        data_o  = data_i[i];
      end
    end
  end

endmodule

//--- design/sb_pkg.sv
// --------------------------------------------------
// scoreboard package
// sizes of the buffer, register file and data path,
// the functional-unit encoding, and the entry,
// write-back and operand structs
// --------------------------------------------------

package sb_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  // must stay a power of two, the full flag is the count msb
  localparam int unsigned NR_ENTRIES  = 8;
  localparam int unsigned TRANS_ID_W  = $clog2(NR_ENTRIES);

  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned NR_REGS     = 2 ** REG_ADDR_W;
  localparam int unsigned XLEN        = 32;

  // result ports coming back from the functional units
  localparam int unsigned NR_WB_PORTS = 2;

  // --------------------------------------------------
  // functional units
  // --------------------------------------------------
  // NONE must stay zero, an idle selector reads as NONE
  typedef enum logic [2:0] {
    NONE  = 3'd0,
    ALU   = 3'd1,
    LOAD  = 3'd2,
    STORE = 3'd3,
    MULT  = 3'd4,
    CSR   = 3'd5
  } fu_t;

  // --------------------------------------------------
  // structs
  // --------------------------------------------------
  // one in-flight instruction, 78 bits
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    fu_t                   fu;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
    // result is present
    logic                  valid;
    logic                  ex_valid;
    logic [TRANS_ID_W-1:0] trans_id;
    // slot is occupied
    logic                  issued;
  } sb_entry_t;

  // one write-back port, a single-cycle pulse
  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       data;
    logic                  ex_valid;
  } wb_t;

  // forwarded operand for one read port
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;
  } operand_t;

endpackage
